/* flist.f */
hw/reg_map_pkg.sv
hw/motor_pkg.sv
hw/spi_target.sv
hw/reg_file.sv
hw/drive_uart_tx.sv
hw/servo_pwm.sv
hw/motor_ctrl_top.sv
verification/tb_credit_assert.sv
verification/tb_monitor.sv
verification/tb_top.sv

/* hw/drive_uart_tx.sv */
/*
 * 8N1 UART transmitter for one drive motor, one frame per
 * cmd_valid, credit returned when the stop bit ends
 */
`timescale 1ns/10ps

module drive_uart_tx (
    input  logic                  clock,
    input  logic                  arst_n,
    input  motor_pkg::drive_cmd_t cmd,
    input  logic                  cmd_valid,
    output logic                  credit,
    output logic                  uart_tx
);
    import motor_pkg::*;

    logic                               busy;       // Frame in flight
    logic [$clog2(BAUD_DIVISION)-1:0]   baud_cnt;
    logic [3:0]                         bit_cnt;    // 0 start, 1..8 data, 9 stop
    logic [$bits(drive_cmd_t):0]        frame;      // Remaining data plus stop
    logic                               baud_tick;

    assign baud_tick = (baud_cnt == $bits(baud_cnt)'(BAUD_DIVISION - 1));

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            busy     <= 1'b0;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            credit   <= 1'b0;
            uart_tx  <= 1'b1;                   // Line idles high
        end else begin
            credit <= 1'b0;
            if (!busy) begin
                if (cmd_valid) begin
                    busy     <= 1'b1;
                    baud_cnt <= '0;
                    bit_cnt  <= '0;
                    uart_tx  <= 1'b0;           // Start bit
                end
            end else if (baud_tick) begin
                baud_cnt <= '0;
                if (bit_cnt == 4'd9) begin
                    busy   <= 1'b0;             // Stop bit done
                    credit <= 1'b1;
                end else begin
                    uart_tx <= frame[0];
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end else begin
                baud_cnt <= baud_cnt + 1'b1;
            end
        end
    end

    // LSB first, ones shift in behind the stop bit
    always_ff @(posedge clock) begin
        if (!busy && cmd_valid)
            frame <= {1'b1, cmd};
        else if (busy && baud_tick)
            frame <= {1'b1, frame[$bits(drive_cmd_t):1]};
    end

endmodule

/* hw/motor_ctrl_top.sv */
/*
 * Motor command subsystem top: SPI target, register file,
 * drive UARTs and servo PWMs
 */
`timescale 1ns/10ps

module motor_ctrl_top (
    input  logic                              clock,
    input  logic                              arst_n,
    input  logic                              spi_clock,
    input  logic                              cs_n,
    input  logic                              mosi,
    output logic                              miso,
    input  logic [3:0]                        fault,
    output logic [motor_pkg::NUM_MOTORS-1:0]  sd_uart,
    output logic [motor_pkg::NUM_MOTORS-1:0]  servo_pwm,
    output logic                              status_fault,
    output logic                              status_pi,
    output logic                              status_ps4
);
    import reg_map_pkg::*;
    import motor_pkg::*;

    reg_req_t              req;                     // SPI to register file
    reg_data_t             rdata;
    drive_cmd_t            drive_cmd [NUM_MOTORS];
    logic [NUM_MOTORS-1:0] cmd_valid;
    logic [NUM_MOTORS-1:0] credit;
    servo_pos_t            servo_pos [NUM_MOTORS];

    ////////////////////
    // Host side
    ////////////////////
    spi_target u_spi (
        .clock     (clock),
        .arst_n    (arst_n),
        .spi_clock (spi_clock),
        .cs_n      (cs_n),
        .mosi      (mosi),
        .miso      (miso),
        .req       (req),
        .rdata     (rdata)
    );

    reg_file u_regs (
        .clock        (clock),
        .arst_n       (arst_n),
        .req          (req),
        .rdata        (rdata),
        .fault        (fault),
        .cmd          (drive_cmd),
        .cmd_valid    (cmd_valid),
        .credit       (credit),
        .servo_pos    (servo_pos),
        .status_fault (status_fault),
        .status_pi    (status_pi),
        .status_ps4   (status_ps4)
    );

    ////////////////////
    // Motor side
    ////////////////////
    for (genvar i = 0; i < NUM_MOTORS; i++) begin : g_drive
        drive_uart_tx u_uart (
            .clock     (clock),
            .arst_n    (arst_n),
            .cmd       (drive_cmd[i]),
            .cmd_valid (cmd_valid[i]),
            .credit    (credit[i]),             // Back to the register file
            .uart_tx   (sd_uart[i])
        );
    end

    for (genvar i = 0; i < NUM_MOTORS; i++) begin : g_servo
        servo_pwm u_pwm (
            .clock      (clock),
            .arst_n     (arst_n),
            .position   (servo_pos[i]),
            .pwm_signal (servo_pwm[i])
        );
    end

endmodule

/* hw/motor_pkg.sv */
/*
 * Motor side definitions: channel count, UART bit timing,
 * PWM width, drive command and servo position types
 */
package motor_pkg;

    localparam int NUM_MOTORS    = 4;    // Drive and servo channels each
    localparam int BAUD_DIVISION = 116;  // System clocks per UART bit
    localparam int PWM_W         = 8;    // 256 clock PWM period

    // UART payload, sent LSB first so speed goes out before brake
    typedef struct packed {
        logic       brake;          // Bit 7
        logic       enable;
        logic       direction;
        logic [4:0] speed;          // Bits 4:0
    } drive_cmd_t;

    typedef logic [PWM_W-1:0] servo_pos_t;

endpackage

/* hw/reg_file.sv */
/*
 * Register file: address decode, drive/servo/status storage,
 * credit based drive command issue and status LED drive
 */
`timescale 1ns/10ps

module reg_file (
    input  logic                                clock,
    input  logic                                arst_n,
    input  reg_map_pkg::reg_req_t               req,
    output reg_map_pkg::reg_data_t              rdata,
    input  logic [3:0]                          fault,
    output motor_pkg::drive_cmd_t               cmd [motor_pkg::NUM_MOTORS],
    output logic [motor_pkg::NUM_MOTORS-1:0]    cmd_valid,
    input  logic [motor_pkg::NUM_MOTORS-1:0]    credit,
    output motor_pkg::servo_pos_t               servo_pos [motor_pkg::NUM_MOTORS],
    output logic                                status_fault,
    output logic                                status_pi,
    output logic                                status_ps4
);
    import reg_map_pkg::*;
    import motor_pkg::*;

    drive_cmd_t            drive_reg [NUM_MOTORS];
    servo_pos_t            servo_reg [NUM_MOTORS];
    status_ctrl_t          status_reg;
    logic [NUM_MOTORS-1:0] drive_wr;        // Write hit per drive channel
    logic [NUM_MOTORS-1:0] pending;         // Unsent command waiting
    logic [NUM_MOTORS-1:0] credit_held;     // UART ready for one frame
    logic [NUM_MOTORS-1:0] issue;
    reg_data_t             rd_mux;

    ////////////////////
    // Decode and storage
    ////////////////////
    always_comb begin
        for (int i = 0; i < NUM_MOTORS; i++) begin
            drive_wr[i] = req.wr_en && (req.addr == ADDR_DRIVE_BASE + reg_addr_t'(i));
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NUM_MOTORS; i++) begin
                drive_reg[i] <= '0;
                servo_reg[i] <= '0;             // Servos start at zero duty
            end
            status_reg <= '0;
        end else if (req.wr_en) begin
            for (int i = 0; i < NUM_MOTORS; i++) begin
                if (drive_wr[i])
                    drive_reg[i] <= drive_cmd_t'(req.wdata);
                if (req.addr == ADDR_SERVO_BASE + reg_addr_t'(i))
                    servo_reg[i] <= req.wdata;
            end
            if (req.addr == ADDR_STATUS)
                status_reg <= status_ctrl_t'(req.wdata);
        end
    end

    ////////////////////
    // Credit tracking
    ////////////////////
    assign issue = pending & credit_held;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            pending     <= '0;
            credit_held <= '1;                  // One credit per channel
            cmd_valid   <= '0;
        end else begin
            pending     <= (pending & ~issue) | drive_wr;   // Late write re-arms
            credit_held <= (credit_held & ~issue) | credit;
            cmd_valid   <= issue;
        end
    end

    assign cmd       = drive_reg;               // Newest value always on cmd
    assign servo_pos = servo_reg;

    ////////////////////
    // Read path
    ////////////////////
    always_comb begin
        rd_mux = '0;                            // Unmapped reads zero
        for (int i = 0; i < NUM_MOTORS; i++) begin
            if (req.addr == ADDR_DRIVE_BASE + reg_addr_t'(i))
                rd_mux = reg_data_t'(drive_reg[i]);
            if (req.addr == ADDR_SERVO_BASE + reg_addr_t'(i))
                rd_mux = servo_reg[i];
        end
        if (req.addr == ADDR_FAULT)
            rd_mux = reg_data_t'(fault);        // Low nibble
        if (req.addr == ADDR_STATUS)
            rd_mux = reg_data_t'(status_reg);
    end

    always_ff @(posedge clock) begin
        if (req.rd_en)
            rdata <= rd_mux;                    // Held until next read
    end

    // LED test lights everything
    assign status_fault = status_reg.led_test | (|fault);
    assign status_pi    = status_reg.led_test | status_reg.pi_connected;
    assign status_ps4   = status_reg.led_test | status_reg.ps4_connected;

endmodule

/* hw/reg_map_pkg.sv */
/*
 * Register map: address and data types, SPI command byte layout,
 * fixed register addresses, status control bits, register request
 */
package reg_map_pkg;

    localparam int ADDR_W        = 6;   // 64 entry register space
    localparam int DATA_W        = 8;   // One byte per register
    localparam int SPI_WRITE_BIT = 7;   // Write flag in the command byte

    typedef logic [ADDR_W-1:0] reg_addr_t;
    typedef logic [DATA_W-1:0] reg_data_t;

    localparam reg_addr_t ADDR_DRIVE_BASE = 6'h00;  // Drive commands, 0x00..0x03
    localparam reg_addr_t ADDR_SERVO_BASE = 6'h10;  // Servo positions, 0x10..0x13
    localparam reg_addr_t ADDR_FAULT      = 6'h20;  // Read only, faults in low nibble
    localparam reg_addr_t ADDR_STATUS     = 6'h21;  // LED control

    typedef struct packed {
        logic       pi_connected;   // Orange Pi link LED
        logic       ps4_connected;  // Controller link LED
        logic       led_test;       // Force all LEDs on
        logic [4:0] reserved;
    } status_ctrl_t;

    typedef struct packed {
        logic      wr_en;           // Single cycle strobe
        logic      rd_en;           // Single cycle strobe
        reg_addr_t addr;
        reg_data_t wdata;
    } reg_req_t;

endpackage

/* hw/servo_pwm.sv */
/*
 * Servo PWM, free running 256 clock period,
 * duty ratio latched at counter wrap
 */
`timescale 1ns/10ps

module servo_pwm (
    input  logic                  clock,
    input  logic                  arst_n,
    input  motor_pkg::servo_pos_t position,
    output logic                  pwm_signal
);
    import motor_pkg::*;

    logic [PWM_W-1:0] counter;
    servo_pos_t       ratio;            // Duty for the current period

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            counter <= '0;
            ratio   <= '0;              // Output low out of reset
        end else begin
            counter <= counter + 1'b1;
            if (counter == '1)
                ratio <= position;      // New duty from next period
        end
    end

    // High for ratio clocks, zero gives constant low
    assign pwm_signal = (counter < ratio);

endmodule

/* hw/spi_target.sv */
/*
 * SPI mode-0 target, oversampled by the system clock.
 * Two byte transactions: command byte then data byte.
 */
`timescale 1ns/10ps

module spi_target (
    input  logic                   clock,
    input  logic                   arst_n,
    input  logic                   spi_clock,
    input  logic                   cs_n,
    input  logic                   mosi,
    output logic                   miso,
    output reg_map_pkg::reg_req_t  req,
    input  reg_map_pkg::reg_data_t rdata
);
    import reg_map_pkg::*;

    logic [2:0] sclk_sync;      // Two sync stages plus edge history
    logic [1:0] cs_sync;
    logic [1:0] mosi_sync;
    logic       sclk_rise;
    logic       sclk_fall;
    logic       cs_active;
    logic [3:0] bit_cnt;        // Rising edges seen in this transaction
    reg_data_t  shift_in;
    reg_data_t  byte_in;        // Shift register with the current bit
    logic       cmd_write;      // Latched write flag
    reg_addr_t  addr_q;
    reg_data_t  wdata_q;
    logic       wr_en_q;
    logic       rd_en_q;
    logic       rd_load;        // rdata valid this cycle
    reg_data_t  tx_shift;       // Read data going out on miso

    ////////////////////
    // Synchronizers
    ////////////////////
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            sclk_sync <= '0;
            cs_sync   <= '1;            // Deselected
            mosi_sync <= '0;
        end else begin
            sclk_sync <= {sclk_sync[1:0], spi_clock};
            cs_sync   <= {cs_sync[0], cs_n};
            mosi_sync <= {mosi_sync[0], mosi};
        end
    end

    assign sclk_rise = sclk_sync[1] & ~sclk_sync[2];
    assign sclk_fall = ~sclk_sync[1] & sclk_sync[2];
    assign cs_active = ~cs_sync[1];
    assign byte_in   = {shift_in[DATA_W-2:0], mosi_sync[1]};

    ////////////////////
    // Bit count and requests
    ////////////////////
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            bit_cnt   <= '0;
            cmd_write <= 1'b0;
            wr_en_q   <= 1'b0;
            rd_en_q   <= 1'b0;
            rd_load   <= 1'b0;
        end else begin
            wr_en_q <= 1'b0;            // Strobes last one clock
            rd_en_q <= 1'b0;
            rd_load <= rd_en_q;
            if (!cs_active) begin
                bit_cnt <= '0;          // Frame restarts on deselect
            end else if (sclk_rise) begin
                bit_cnt <= bit_cnt + 4'd1;
                if (bit_cnt == 4'd7) begin
                    cmd_write <= byte_in[SPI_WRITE_BIT];
                    rd_en_q   <= ~byte_in[SPI_WRITE_BIT];  // Early, before data byte
                end
                if (bit_cnt == 4'd15)
                    wr_en_q <= cmd_write;                  // After 16th edge
            end
        end
    end

    always_ff @(posedge clock) begin
        if (cs_active && sclk_rise) begin
            shift_in <= byte_in;
            if (bit_cnt == 4'd7)
                addr_q <= byte_in[ADDR_W-1:0];
            if (bit_cnt == 4'd15)
                wdata_q <= byte_in;
        end
    end

    assign req = '{wr_en: wr_en_q, rd_en: rd_en_q, addr: addr_q, wdata: wdata_q};

    ////////////////////
    // Read data out
    ////////////////////
    always_ff @(posedge clock) begin
        if (rd_load)
            tx_shift <= rdata;
        else if (cs_active && sclk_rise && bit_cnt == 4'd7)
            tx_shift <= '0;             // Writes return zeros
        else if (cs_active && sclk_fall && bit_cnt[3])
            tx_shift <= {tx_shift[DATA_W-2:0], 1'b0};
    end

    // MSB goes out on the falling edge closing the command byte
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n)
            miso <= 1'b0;
        else if (!cs_active)
            miso <= 1'b0;
        else if (sclk_fall && bit_cnt[3])
            miso <= tx_shift[DATA_W-1];
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the motor controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f flist.f

out=$(./obj_dir/Vtb_top || true)
echo "$out"

# Fails the script when the pass line is missing
echo "$out" | grep -q "^TB PASSED$"

/* verification/tb_credit_assert.sv */
/*
 * Credit protocol assertions for one drive UART, bound into drive_uart_tx
 */
`timescale 1ns/10ps

module tb_credit_assert (
    input logic clock,
    input logic arst_n,
    input logic cmd_valid,
    input logic credit,
    input logic uart_tx,
    input logic busy
);
    // Credit only closes a frame that was running
    credit_after_frame: assert property (@(posedge clock) disable iff (!arst_n)
        credit |-> $past(busy)) else $error("credit pulse with no frame in flight");

    // Register file must not issue into a busy UART
    valid_when_idle: assert property (@(posedge clock) disable iff (!arst_n)
        cmd_valid |-> !busy) else $error("cmd_valid arrived during a frame");

    // Line held at mark level between frames
    idle_line_high: assert property (@(posedge clock) disable iff (!arst_n)
        !busy |-> uart_tx) else $error("uart_tx low outside a frame");

endmodule

bind drive_uart_tx tb_credit_assert u_credit_assert (
    .clock     (clock),
    .arst_n    (arst_n),
    .cmd_valid (cmd_valid),
    .credit    (credit),
    .uart_tx   (uart_tx),
    .busy      (busy)
);

/* verification/tb_monitor.sv */
/*
 * Output checker: UART frame decode per drive channel, servo
 * high time measurement, value compare and error counting
 */
`timescale 1ns/10ps

module tb_monitor (
    input logic       clock,
    input logic       arst_n,
    input logic [3:0] sd_uart,
    input logic [3:0] servo_pwm
);
    import motor_pkg::*;

    int         mismatch_count = 0;
    int         error_count    = 0;
    logic [7:0] exp_vals [4][32];       // Values written per channel, in order
    int         exp_cnt [4]     = '{default: 0};
    int         exp_rd [4]      = '{default: 0};    // Oldest value still allowed
    int         frame_count [4] = '{default: 0};
    logic [7:0] last_frame [4]  = '{default: 8'h00};

    task automatic compare(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("Mismatch at %0t: %s got %02h expected %02h", $time, name, got, exp);
        end
    endtask

    task automatic report_error(input string what);
        error_count++;
        $display("Error at %0t: %s", $time, what);
    endtask

    task automatic expect_frame(input int ch, input logic [7:0] v);
        exp_vals[ch][exp_cnt[ch]] = v;
        exp_cnt[ch]++;
    endtask

    // Frames come out in write order, skipped values were overwritten
    task automatic check_frame(input int ch, input logic [7:0] v);
        int hit;
        hit = -1;
        for (int i = exp_rd[ch]; i < exp_cnt[ch]; i++) begin
            if (hit < 0 && exp_vals[ch][i] == v)
                hit = i;
        end
        if (hit >= 0)
            exp_rd[ch] = hit + 1;
        else
            compare($sformatf("sd_uart[%0d]", ch), v,
                    exp_cnt[ch] > 0 ? exp_vals[ch][exp_cnt[ch]-1] : 8'h00);
        frame_count[ch]++;
        last_frame[ch] = v;
    endtask

    ////////////////////
    // UART decode
    ////////////////////
    for (genvar c = 0; c < 4; c++) begin : g_rx
        always begin : decode
            logic [7:0] data;
            @(negedge clock);
            if (arst_n && sd_uart[c] == 1'b0) begin
                repeat (BAUD_DIVISION/2 - 1) @(negedge clock);     // Middle of start bit
                if (sd_uart[c] !== 1'b0) begin
                    report_error($sformatf("sd_uart[%0d] start bit too short", c));
                end else begin
                    for (int i = 0; i < 8; i++) begin
                        repeat (BAUD_DIVISION) @(negedge clock);
                        data[i] = sd_uart[c];                       // LSB first
                    end
                    repeat (BAUD_DIVISION) @(negedge clock);
                    if (sd_uart[c] !== 1'b1)
                        report_error($sformatf("sd_uart[%0d] stop bit low", c));
                    check_frame(c, data);
                end
            end
        end
    end

    ////////////////////
    // Servo PWM
    ////////////////////
    task automatic measure_high(input int ch, output int high, output bit ok);
        int t;
        t    = 0;
        high = 0;
        while (t < 1000 && servo_pwm[ch] !== 1'b0) begin   // Skip pulse in progress
            @(negedge clock);
            t++;
        end
        while (t < 1000 && servo_pwm[ch] !== 1'b1) begin
            @(negedge clock);
            t++;
        end
        while (t < 1000 && servo_pwm[ch] === 1'b1) begin
            high++;
            @(negedge clock);
            t++;
        end
        ok = (t < 1000);
    endtask

    task automatic watch_low(input int ch, input int clocks, output bit ok);
        ok = 1'b1;
        for (int t = 0; t < clocks; t++) begin
            @(negedge clock);
            if (servo_pwm[ch] !== 1'b0)
                ok = 1'b0;
        end
    endtask

endmodule

/* verification/tb_top.sv */
/*
 * Testbench top: clock, reset, LFSR data, register map reference,
 * SPI host stimulus, DUT and output checker
 */
`timescale 1ns/10ps

module tb_top;
    import reg_map_pkg::*;
    import motor_pkg::*;

    logic        clock;
    logic        arst_n;
    logic        spi_clock;
    logic        cs_n;
    logic        mosi;
    logic        miso;
    logic [3:0]  fault;
    logic [3:0]  sd_uart;
    logic [3:0]  servo_pwm;
    logic        status_fault;
    logic        status_pi;
    logic        status_ps4;
    logic [31:0] lfsr_state;
    reg_data_t   model [64];            // Expected register contents
    event        abort_run;             // A wait ran out of time

    initial clock = 1'b0;
    always #2 clock = ~clock;           // 4 ns period

    motor_ctrl_top DUT (.*);

    tb_monitor u_mon (
        .clock     (clock),
        .arst_n    (arst_n),
        .sd_uart   (sd_uart),
        .servo_pwm (servo_pwm)
    );

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    ////////////////////
    // Reference model
    ////////////////////
    function automatic reg_data_t ref_read(input reg_addr_t a);
        if (a <= 6'h03 || (a >= 6'h10 && a <= 6'h13) || a == 6'h21)
            return model[a];
        if (a == 6'h20)
            return {4'h0, fault};
        return 8'h00;                   // Unmapped
    endfunction

    function automatic logic [7:0] ref_leds();
        logic t;
        t = model[6'h21][5];            // led_test
        return {5'b0, t | (|fault), t | model[6'h21][7], t | model[6'h21][6]};
    endfunction

    task automatic print_counts();
        $display("Checks done: %0d mismatches, %0d other errors",
                 u_mon.mismatch_count, u_mon.error_count);
    endtask

    task automatic timeout_fail(input string what);
        $display("Timeout while waiting for %s", what);
        -> abort_run;
        forever @(posedge clock);       // Stimulus stops here
    endtask

    initial begin : abort_on_timeout
        @(abort_run);
        print_counts();
        $display("TB FAILED");
        $finish;
    end

    ////////////////////
    // SPI host
    ////////////////////
    task automatic spi_transfer(input logic [15:0] frame, output reg_data_t rd);
        rd = '0;
        @(posedge clock);
        cs_n <= 1'b0;
        repeat (8) @(posedge clock);
        for (int i = 0; i < 16; i++) begin
            mosi <= frame[15-i];        // Changes with the falling SPI edge
            repeat (8) @(posedge clock);
            if (i >= 8)
                rd = {rd[6:0], miso};   // Stable since the last falling edge
            spi_clock <= 1'b1;
            repeat (8) @(posedge clock);
            spi_clock <= 1'b0;
        end
        repeat (8) @(posedge clock);
        cs_n <= 1'b1;
        repeat (16) @(posedge clock);   // Write has landed by now
    endtask

    task automatic spi_write(input reg_addr_t a, input reg_data_t d);
        reg_data_t unused;
        model[a] = d;
        spi_transfer({2'b10, a, d}, unused);
    endtask

    task automatic check_read(input reg_addr_t a);
        reg_data_t got;
        spi_transfer({2'b00, a, 8'h00}, got);
        u_mon.compare($sformatf("reg[%02h]", a), got, ref_read(a));
    endtask

    task automatic wait_frame(input int ch, input int count);
        int t;
        t = 0;
        while (u_mon.frame_count[ch] < count && t < 4000) begin
            @(posedge clock);
            t++;
        end
        if (t >= 4000)
            timeout_fail($sformatf("a frame on sd_uart[%0d]", ch));
    endtask

    initial begin : main
        logic [31:0] r;
        logic [31:0] v;
        logic [7:0]  w [4];
        int          base [4];
        int          high;
        int          t;
        bit          ok;
        lfsr_state = 32'h255b_0799;
        arst_n     = 1'b0;
        spi_clock  = 1'b0;
        cs_n       = 1'b1;
        mosi       = 1'b0;
        fault      = 4'h0;
        for (int i = 0; i < 64; i++)
            model[i] = 8'h00;
        repeat (5) @(posedge clock);
        arst_n <= 1'b1;
        repeat (5) @(posedge clock);

        // Readback of servo, status and unmapped registers
        for (int i = 0; i < 8; i++) begin
            random_bits(2, r);
            random_bits(8, v);
            spi_write(ADDR_SERVO_BASE + reg_addr_t'(r[1:0]), v[7:0]);
        end
        random_bits(8, v);
        spi_write(ADDR_STATUS, v[7:0]);
        for (int i = 0; i < 4; i++)
            check_read(ADDR_SERVO_BASE + reg_addr_t'(i));
        check_read(ADDR_STATUS);
        check_read(6'h05);
        check_read(6'h1a);
        check_read(6'h3f);

        // One write gives one frame on its own channel
        for (int ch = 0; ch < 4; ch++) begin
            for (int k = 0; k < 4; k++)
                base[k] = u_mon.frame_count[k];
            random_bits(8, v);
            u_mon.expect_frame(ch, v[7:0]);
            spi_write(ADDR_DRIVE_BASE + reg_addr_t'(ch), v[7:0]);
            wait_frame(ch, base[ch] + 1);
            repeat (12 * BAUD_DIVISION) @(posedge clock);  // Room for a stray frame
            for (int k = 0; k < 4; k++)
                u_mon.compare($sformatf("frame count sd_uart[%0d]", k),
                              8'(u_mon.frame_count[k]), 8'(base[k] + (k == ch)));
            check_read(ADDR_DRIVE_BASE + reg_addr_t'(ch));
        end

        // Back pressure with writes landing mid frame
        base[2] = u_mon.frame_count[2];
        for (int i = 0; i < 4; i++) begin
            random_bits(6, v);
            w[i] = {v[5:0], 2'(i)};             // Distinct values
            u_mon.expect_frame(2, w[i]);
            spi_write(ADDR_DRIVE_BASE + 6'd2, w[i]);
        end
        t = 0;
        while ((u_mon.frame_count[2] == base[2] || u_mon.last_frame[2] != w[3]) && t < 5000) begin
            @(posedge clock);
            t++;
        end
        if (t >= 5000)
            timeout_fail("the last value on sd_uart[2]");
        repeat (1500) @(posedge clock);
        if (u_mon.frame_count[2] - base[2] > 4)
            u_mon.report_error("more frames on sd_uart[2] than writes");
        u_mon.compare("last frame sd_uart[2]", u_mon.last_frame[2], w[3]);

        // Servo high time on the second full period
        for (int ch = 0; ch < 4; ch++) begin
            random_bits(8, v);
            spi_write(ADDR_SERVO_BASE + reg_addr_t'(ch), v[7:0] | 8'h01);
            u_mon.measure_high(ch, high, ok);
            if (ok)
                u_mon.measure_high(ch, high, ok);
            if (!ok)
                timeout_fail($sformatf("a pulse on servo_pwm[%0d]", ch));
            u_mon.compare($sformatf("servo_pwm[%0d] high time", ch), 8'(high), v[7:0] | 8'h01);
        end
        spi_write(ADDR_SERVO_BASE, 8'h00);
        repeat (300) @(posedge clock);          // Let the old period finish
        u_mon.watch_low(0, 600, ok);
        if (!ok)
            u_mon.report_error("servo_pwm[0] pulsed at position 0");

        // Faults and status LEDs
        random_bits(4, v);
        @(posedge clock);
        fault <= v[3:0] | 4'h1;
        repeat (4) @(posedge clock);
        check_read(ADDR_FAULT);
        spi_write(ADDR_STATUS, 8'h80);          // Pi link only
        @(negedge clock);
        u_mon.compare("status leds", {5'b0, status_fault, status_pi, status_ps4}, ref_leds());
        @(posedge clock);
        fault <= 4'h0;
        spi_write(ADDR_STATUS, 8'h40);          // PS4 link only
        @(negedge clock);
        u_mon.compare("status leds", {5'b0, status_fault, status_pi, status_ps4}, ref_leds());
        spi_write(ADDR_STATUS, 8'h20);          // LED test
        @(negedge clock);
        u_mon.compare("status leds", {5'b0, status_fault, status_pi, status_ps4}, ref_leds());

        print_counts();
        if (u_mon.mismatch_count + u_mon.error_count == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule
